// File: filelist.f
verilog/spin_readout_pkg.sv
verilog/spin_synchronizer.sv
verilog/analog_tx.sv
verilog/spin_fifo.sv
verilog/spin_readout_top.sv
verification/tb_spin_readout.sv

// File: Makefile
# Verilator build and run of the spin readout testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_spin_readout
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_MSG)"; then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

// File: verification/tb_spin_readout.sv
// Self-checking testbench for spin_readout_top with a macro model and a consumer model.
// The synchronizer select only changes while no vector is in flight.
`timescale 1ns/1ps

module tb_spin_readout;
    import spin_readout_pkg::*;

    // all tests together need well under 200 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clk_i;
    logic                  rst_i;
    logic                  en_i;
    logic                  cfg_we_i;
    logic [SYNC_SEL_W-1:0] cfg_sync_sel_i;
    logic [SYNC_SEL_W-1:0] cfg_sync_sel_o;
    logic [NUM_SPIN-1:0]   spin_i;
    logic                  cmpt_finish_i;
    logic                  spin_valid_o;
    logic                  spin_ready_i;
    logic [NUM_SPIN-1:0]   spin_o;
    logic                  idle_o;
    logic                  overrun_o;

    // vectors sent by the macro model and not yet delivered
    logic [NUM_SPIN-1:0] exp_q[$];
    logic [NUM_SPIN-1:0] exp_spin;
    logic [NUM_SPIN-1:0] last_spin;
    string               test_name;
    int                  seed;
    int                  rnd;
    int                  old_sel;
    int                  cycle_cnt;

    spin_readout_top u_dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .en_i           (en_i),
        .cfg_we_i       (cfg_we_i),
        .cfg_sync_sel_i (cfg_sync_sel_i),
        .cfg_sync_sel_o (cfg_sync_sel_o),
        .spin_i         (spin_i),
        .cmpt_finish_i  (cmpt_finish_i),
        .spin_valid_o   (spin_valid_o),
        .spin_ready_i   (spin_ready_i),
        .spin_o         (spin_o),
        .idle_o         (idle_o),
        .overrun_o      (overrun_o)
    );

    always #10 clk_i = ~clk_i;

    task abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input int exp, input int act);
        assert (act == exp) else begin
            $display("Error: %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // advance to the drive point after the next edge
    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic write_sel(input logic [SYNC_SEL_W-1:0] sel);
        cfg_sync_sel_i = sel;
        cfg_we_i       = 1'b1;
        step();
        cfg_we_i       = 1'b0;
    endtask

    // macro model pulse
    // only an enabled vector is expected at the output
    task automatic send_vector();
        spin_i        = NUM_SPIN'($random(seed));
        last_spin     = spin_i;
        cmpt_finish_i = 1'b1;
        if (en_i) begin
            exp_q.push_back(spin_i);
        end
        step();
        cmpt_finish_i = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            step();
        end
    endtask

    // scoreboard on every accepted output vector
    always @(posedge clk_i) begin
        if (!rst_i && spin_valid_o && spin_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("Error: %s: output transfer with no vector outstanding", test_name);
                abort_run();
            end else begin
                exp_spin = exp_q.pop_front();
                check_eq("spin_o", int'(exp_spin), int'(spin_o));
            end
        end
    end

    // consumer side handshake rule
    a_out_hold: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (spin_valid_o && !spin_ready_i) |=> (spin_valid_o && $stable(spin_o))
    ) else begin
        $display("Error: %s: spin_o dropped or changed before it was taken", test_name);
        abort_run();
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d cycles in %s", TIMEOUT_CYCLES, test_name);
            abort_run();
        end
    end

    initial begin
        seed           = 94991;
        cycle_cnt      = 0;
        test_name      = "reset";
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        en_i           = 1'b0;
        cfg_we_i       = 1'b0;
        cfg_sync_sel_i = '0;
        spin_i         = '0;
        cmpt_finish_i  = 1'b0;
        spin_ready_i   = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        en_i  = 1'b1;

        check_eq("idle_o", 1, int'(idle_o));
        check_eq("spin_valid_o", 0, int'(spin_valid_o));
        check_eq("overrun_o", 0, int'(overrun_o));
        check_eq("cfg_sync_sel_o", (1 << SYNC_SEL_W) - 1, int'(cfg_sync_sel_o));

        // output rises on the sel+3rd edge counting the sampling edge
        test_name    = "latency";
        spin_ready_i = 1'b1;
        for (int s = 0; s < SYNC_DEPTH; s++) begin
            write_sel(SYNC_SEL_W'(s));
            check_eq("cfg_sync_sel_o", s, int'(cfg_sync_sel_o));
            send_vector();
            for (int k = 1; k < s + 3; k++) begin
                check_eq("spin_valid_o early", 0, int'(spin_valid_o));
                step();
            end
            check_eq("spin_valid_o on time", 1, int'(spin_valid_o));
            check_eq("spin_o", int'(last_spin), int'(spin_o));
            wait_drained();
        end

        // FIFO fills and the transmit stage holds one more
        test_name    = "backpressure";
        spin_ready_i = 1'b0;
        repeat (FIFO_DEPTH + 1) begin
            send_vector();
            step();
        end
        repeat (SYNC_DEPTH + 3) step();
        check_eq("idle_o while holding", 0, int'(idle_o));
        while (exp_q.size() != 0) begin
            rnd          = $random(seed);
            spin_ready_i = rnd[0];
            step();
        end
        spin_ready_i = 1'b0;
        check_eq("overrun_o", 0, int'(overrun_o));

        // the fifth vector is replaced by the sixth
        test_name = "overrun";
        repeat (FIFO_DEPTH + 2) begin
            send_vector();
            step();
        end
        exp_q.delete(FIFO_DEPTH);
        repeat (SYNC_DEPTH + 3) step();
        check_eq("overrun_o set", 1, int'(overrun_o));
        spin_ready_i = 1'b1;
        wait_drained();
        check_eq("overrun_o sticky", 1, int'(overrun_o));

        test_name = "enable gating";
        en_i      = 1'b0;
        old_sel   = int'(cfg_sync_sel_o);
        write_sel(~cfg_sync_sel_o);
        check_eq("cfg_sync_sel_o", old_sel, int'(cfg_sync_sel_o));
        send_vector();
        repeat (SYNC_DEPTH + 4) begin
            check_eq("spin_valid_o", 0, int'(spin_valid_o));
            check_eq("idle_o", 1, int'(idle_o));
            step();
        end
        en_i = 1'b1;
        check_eq("overrun_o sticky", 1, int'(overrun_o));

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verilog/spin_readout_top.sv
// Spin readout path from the analog macro to a digital consumer.
// Both handshakes follow valid/ready; data must stay put until the transfer.
`timescale 1ns/1ps

module spin_readout_top (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   en_i,
    input  logic                                   cfg_we_i,
    input  logic [spin_readout_pkg::SYNC_SEL_W-1:0] cfg_sync_sel_i,
    output logic [spin_readout_pkg::SYNC_SEL_W-1:0] cfg_sync_sel_o,
    input  logic [spin_readout_pkg::NUM_SPIN-1:0]   spin_i,
    input  logic                                   cmpt_finish_i,
    output logic                                   spin_valid_o,
    input  logic                                   spin_ready_i,
    output logic [spin_readout_pkg::NUM_SPIN-1:0]   spin_o,
    output logic                                   idle_o,
    output logic                                   overrun_o
);
    import spin_readout_pkg::*;

    // transmit stage to FIFO
    logic                tx_valid;
    logic                tx_ready;
    logic [NUM_SPIN-1:0] tx_spin;

    analog_tx u_tx (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .en_i           (en_i),
        .cfg_we_i       (cfg_we_i),
        .cfg_sync_sel_i (cfg_sync_sel_i),
        .cfg_sync_sel_o (cfg_sync_sel_o),
        .spin_i         (spin_i),
        .cmpt_finish_i  (cmpt_finish_i),
        .tx_valid_o     (tx_valid),
        .tx_ready_i     (tx_ready),
        .tx_spin_o      (tx_spin),
        .idle_o         (idle_o),
        .overrun_o      (overrun_o)
    );

    spin_fifo u_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (tx_valid),
        .in_ready_o  (tx_ready),
        .in_data_i   (tx_spin),
        .out_valid_o (spin_valid_o),
        .out_ready_i (spin_ready_i),
        .out_data_o  (spin_o)
    );

endmodule

// File: verilog/spin_fifo.sv
// Spin vector FIFO with a registered head word.
// in_ready_o also rises when full and the head is popped on the same edge.
`timescale 1ns/1ps

module spin_fifo (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 in_valid_i,
    output logic                                 in_ready_o,
    input  logic [spin_readout_pkg::NUM_SPIN-1:0] in_data_i,
    output logic                                 out_valid_o,
    input  logic                                 out_ready_i,
    output logic [spin_readout_pkg::NUM_SPIN-1:0] out_data_o
);
    import spin_readout_pkg::*;

    logic [NUM_SPIN-1:0]   mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_next;
    logic [FIFO_CNT_W-1:0] count_q;
    logic [NUM_SPIN-1:0]   head_q;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full        = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_data_o  = head_q;
    assign in_ready_o  = !full || out_ready_i;
    assign push        = in_valid_i & in_ready_o;
    assign pop         = out_valid_o & out_ready_i;
    assign rd_ptr_next = rd_ptr_q + 1'b1;

    // pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_next;
            end
            unique case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // head word also stays in mem so a full push may reuse its slot
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= in_data_i;
        end
        if (pop) begin
            if (count_q > FIFO_CNT_W'(1)) begin
                head_q <= mem[rd_ptr_next];
            end else if (push) begin
                head_q <= in_data_i;
            end
        end else if (!out_valid_o && push) begin
            // empty FIFO passes the new word straight to the output
            head_q <= in_data_i;
        end
    end

    a_count_bound: assert property (
        @(posedge clk_i) disable iff (rst_i)
        count_q <= FIFO_CNT_W'(FIFO_DEPTH)
    ) else $error("spin_fifo: occupancy above depth");

endmodule

// File: verilog/analog_tx.sv
// Transmit stage between the synchronizer and the digital side.
// A new vector always replaces a held one; the loss is flagged on overrun_o
// until reset.
`timescale 1ns/1ps

module analog_tx (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   en_i,
    input  logic                                   cfg_we_i,
    input  logic [spin_readout_pkg::SYNC_SEL_W-1:0] cfg_sync_sel_i,
    output logic [spin_readout_pkg::SYNC_SEL_W-1:0] cfg_sync_sel_o,
    input  logic [spin_readout_pkg::NUM_SPIN-1:0]   spin_i,
    input  logic                                   cmpt_finish_i,
    output logic                                   tx_valid_o,
    input  logic                                   tx_ready_i,
    output logic [spin_readout_pkg::NUM_SPIN-1:0]   tx_spin_o,
    output logic                                   idle_o,
    output logic                                   overrun_o
);
    import spin_readout_pkg::*;

    logic [SYNC_SEL_W-1:0] sync_sel_q;
    logic                  sync_valid;
    logic [NUM_SPIN-1:0]   sync_data;
    logic [NUM_SPIN-1:0]   spin_q;
    tx_state_e             state_q;
    tx_state_e             state_d;
    logic                  transfer;
    logic                  overrun_q;

    spin_synchronizer u_sync (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .en_i      (en_i),
        .data_i    (spin_i),
        .sel_i     (sync_sel_q),
        .capture_i (cmpt_finish_i),
        .valid_o   (sync_valid),
        .data_o    (sync_data)
    );

    assign transfer = tx_valid_o & tx_ready_i;

    // a load wins over a transfer on the same edge
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            TX_IDLE: if (sync_valid) state_d = TX_HOLD;
            TX_HOLD: if (transfer && !sync_valid) state_d = TX_IDLE;
            default: state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= TX_IDLE;
            sync_sel_q <= SYNC_SEL_RESET;
            overrun_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // config writes only while enabled
            if (en_i && cfg_we_i) begin
                sync_sel_q <= cfg_sync_sel_i;
            end
            // held vector replaced before it was taken
            if (sync_valid && tx_valid_o && !tx_ready_i) begin
                overrun_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sync_valid) begin
            spin_q <= sync_data;
        end
    end

    assign tx_valid_o     = (state_q == TX_HOLD);
    assign tx_spin_o      = spin_q;
    assign idle_o         = (state_q == TX_IDLE);
    assign overrun_o      = overrun_q;
    assign cfg_sync_sel_o = sync_sel_q;

    a_hold_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (tx_valid_o && !tx_ready_i && !sync_valid) |=> (tx_valid_o && $stable(tx_spin_o))
    ) else $error("analog_tx: held vector changed before transfer");

    a_overrun_sticky: assert property (
        @(posedge clk_i) disable iff (rst_i)
        overrun_o |=> overrun_o
    ) else $error("analog_tx: overrun flag cleared without reset");

endmodule

// File: verilog/spin_synchronizer.sv
// Run-time selectable depth synchronizer for the macro spin vector.
// Inputs are forced to zero while en_i is low, as isolation cells would do.
// Changing sel_i with vectors in flight may drop or repeat one of them.
`timescale 1ns/1ps

module spin_synchronizer (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   en_i,
    input  logic [spin_readout_pkg::NUM_SPIN-1:0]   data_i,
    input  logic [spin_readout_pkg::SYNC_SEL_W-1:0] sel_i,
    input  logic                                   capture_i,
    output logic                                   valid_o,
    output logic [spin_readout_pkg::NUM_SPIN-1:0]   data_o
);
    import spin_readout_pkg::*;

    logic [NUM_SPIN-1:0]   data_gated;
    logic                  capture_gated;
    logic [SYNC_DEPTH-1:0] valid_q;
    logic [NUM_SPIN-1:0]   data_q [SYNC_DEPTH];
    // back-to-back capture history per stage
    logic [SYNC_DEPTH-1:0] pair_hist_q;

    // isolation model
    assign data_gated    = en_i ? data_i : '0;
    assign capture_gated = en_i & capture_i;

    // valid and capture history pipeline
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q     <= '0;
            pair_hist_q <= '0;
        end else begin
            valid_q     <= {valid_q[SYNC_DEPTH-2:0], capture_gated};
            pair_hist_q <= {pair_hist_q[SYNC_DEPTH-2:0], capture_gated & valid_q[0]};
        end
    end

    always_ff @(posedge clk_i) begin
        data_q[0] <= data_gated;
        for (int i = 1; i < SYNC_DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    // tap picked at run time
    assign valid_o = valid_q[sel_i];
    assign data_o  = data_q[sel_i];

    // two valid cycles in a row only come from two captures in a row
    a_single_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (valid_o && $past(valid_o) && $stable(sel_i)) |-> (|pair_hist_q)
    ) else $error("synchronizer: repeated valid without back-to-back capture");

endmodule

// File: verilog/spin_readout_pkg.sv
// Shared sizes and types for the spin readout path.
// FIFO_DEPTH must be a power of two so the FIFO pointers wrap on their own.

package spin_readout_pkg;

    // spins per vector
    localparam int NUM_SPIN = 16;

    // synchronizer stages and the width of the stage select
    localparam int SYNC_DEPTH = 4;
    localparam int SYNC_SEL_W = $clog2(SYNC_DEPTH);

    // deepest setting after reset
    localparam logic [SYNC_SEL_W-1:0] SYNC_SEL_RESET = {SYNC_SEL_W{1'b1}};

    // vectors held by the output FIFO
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // transmit stage state
    typedef enum logic {
        TX_IDLE,
        TX_HOLD
    } tx_state_e;

endpackage
